//--- logic/hb_bridge_pkg.sv
package hb_bridge_pkg;

  ////////////////////
  // host bus
  ////////////////////
  localparam int axil_data_width_lp = 32;
  localparam int axil_addr_width_lp = 10;
  localparam int reg_idx_width_lp   = 8;

  // register map, word indices (byte address bits 9:2)
  localparam logic [reg_idx_width_lp-1:0] reg_sys_reset_lp = 8'd0;
  localparam logic [reg_idx_width_lp-1:0] reg_dram_base_lp = 8'd1;
  localparam logic [reg_idx_width_lp-1:0] reg_h2f_data_lp  = 8'd2;
  localparam logic [reg_idx_width_lp-1:0] reg_h2f_free_lp  = 8'd3;
  localparam logic [reg_idx_width_lp-1:0] reg_f2h_data_lp  = 8'd4;
  localparam logic [reg_idx_width_lp-1:0] reg_f2h_count_lp = 8'd5;

  localparam int fifo_depth_lp       = 4;
  localparam int fifo_count_width_lp = 3;
  localparam int reset_depth_lp      = 3;

  localparam logic [1:0] resp_okay_lp   = 2'd0;
  localparam logic [1:0] resp_slverr_lp = 2'd2;

  ////////////////////
  // dram side
  ////////////////////
  localparam int dram_addr_width_lp   = 32;
  localparam int cache_id_width_lp    = 4;
  localparam int line_offset_width_lp = 24;
  localparam int dma_addr_width_lp    = 28;

  typedef struct packed {
    logic [dram_addr_width_lp-cache_id_width_lp-line_offset_width_lp-1:0] pad;
    logic [cache_id_width_lp-1:0]                                         cache_id;
    logic [line_offset_width_lp-1:0]                                      line_offset;
  } dram_addr_fields_s;

  // same dram word, either flat or split into cache id and line offset
  typedef union packed {
    logic [dram_addr_width_lp-1:0] flat;
    dram_addr_fields_s             fields;
  } dram_addr_u;

endpackage

//--- logic/reg_cmd_if.sv
`timescale 1ns/1ps

interface reg_cmd_if
  (input logic aclk
   );

  import hb_bridge_pkg::*;

  // command, front to bank
  logic                            cmd_v;
  logic                            cmd_write;
  logic [reg_idx_width_lp-1:0]     cmd_idx;
  logic [axil_data_width_lp-1:0]   cmd_wdata;
  logic [axil_data_width_lp/8-1:0] cmd_wstrb;
  logic                            cmd_ready;

  // result strobe, bank to response stage
  logic                            rsp_v;
  logic                            rsp_write;
  logic [axil_data_width_lp-1:0]   rsp_rdata;
  logic [1:0]                      rsp_code;

  modport front
    (input aclk, cmd_ready
     , output cmd_v, cmd_write, cmd_idx, cmd_wdata, cmd_wstrb
     );

  modport bank
    (input aclk, cmd_v, cmd_write, cmd_idx, cmd_wdata, cmd_wstrb
     , output cmd_ready, rsp_v, rsp_write, rsp_rdata, rsp_code
     );

  modport resp
    (input aclk, rsp_v, rsp_write, rsp_rdata, rsp_code
     );

endinterface

//--- logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo
  (input  logic                                         aclk
   , input  logic                                       rst_n_i

   , input  logic [hb_bridge_pkg::axil_data_width_lp-1:0]  data_i
   , input  logic                                       v_i
   , output logic                                       ready_o

   , output logic [hb_bridge_pkg::axil_data_width_lp-1:0]  data_o
   , output logic                                       v_o
   , input  logic                                       yumi_i

   , output logic [hb_bridge_pkg::fifo_count_width_lp-1:0] count_o
   );

  import hb_bridge_pkg::*;

  logic [axil_data_width_lp-1:0]  mem_r [fifo_depth_lp];
  logic [fifo_count_width_lp-2:0] wr_ptr_r;
  logic [fifo_count_width_lp-2:0] rd_ptr_r;
  logic [fifo_count_width_lp-1:0] count_r;
  logic                           push;

  assign ready_o = (count_r != fifo_count_width_lp'(fifo_depth_lp));
  assign v_o     = (count_r != '0);
  assign push    = v_i & ready_o;
  assign data_o  = mem_r[rd_ptr_r];
  assign count_o = count_r;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (push != yumi_i)
        count_r <= push ? count_r + 1'b1 : count_r - 1'b1;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

//--- logic/axil_front.sv
`timescale 1ns/1ps

module axil_front
  (input  logic                                          aclk
   , input  logic                                        rst_n_i

   , input  logic [hb_bridge_pkg::axil_addr_width_lp-1:0]   s_axi_awaddr_i
   , input  logic                                        s_axi_awvalid_i
   , output logic                                        s_axi_awready_o

   , input  logic [hb_bridge_pkg::axil_data_width_lp-1:0]   s_axi_wdata_i
   , input  logic [hb_bridge_pkg::axil_data_width_lp/8-1:0] s_axi_wstrb_i
   , input  logic                                        s_axi_wvalid_i
   , output logic                                        s_axi_wready_o

   , input  logic [hb_bridge_pkg::axil_addr_width_lp-1:0]   s_axi_araddr_i
   , input  logic                                        s_axi_arvalid_i
   , output logic                                        s_axi_arready_o

   , reg_cmd_if.front                                    cmd
   );

  import hb_bridge_pkg::*;

  logic                            cmd_v_r;
  logic                            cmd_write_r;
  logic [reg_idx_width_lp-1:0]     cmd_idx_r;
  logic [axil_data_width_lp-1:0]   cmd_wdata_r;
  logic [axil_data_width_lp/8-1:0] cmd_wstrb_r;
  logic                            advance;
  logic                            wr_pending;
  logic                            wr_go;
  logic                            rd_go;

  // the command slot frees up when empty or when the bank takes it
  assign advance    = ~cmd_v_r | cmd.cmd_ready;
  assign wr_pending = s_axi_awvalid_i & s_axi_wvalid_i;
  assign wr_go      = wr_pending & advance;
  assign rd_go      = s_axi_arvalid_i & ~wr_pending & advance;

  assign s_axi_awready_o = wr_go;
  assign s_axi_wready_o  = wr_go;
  assign s_axi_arready_o = rd_go;

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cmd_v_r <= 1'b0;
    else if (advance)
      cmd_v_r <= wr_go | rd_go;
  end

  // byte address down to word index
  always_ff @(posedge aclk)
  begin
    if (wr_go)
    begin
      cmd_write_r <= 1'b1;
      cmd_idx_r   <= s_axi_awaddr_i[axil_addr_width_lp-1:2];
      cmd_wdata_r <= s_axi_wdata_i;
      cmd_wstrb_r <= s_axi_wstrb_i;
    end
    else if (rd_go)
    begin
      cmd_write_r <= 1'b0;
      cmd_idx_r   <= s_axi_araddr_i[axil_addr_width_lp-1:2];
    end
  end

  assign cmd.cmd_v     = cmd_v_r;
  assign cmd.cmd_write = cmd_write_r;
  assign cmd.cmd_idx   = cmd_idx_r;
  assign cmd.cmd_wdata = cmd_wdata_r;
  assign cmd.cmd_wstrb = cmd_wstrb_r;

endmodule

//--- logic/reg_bank.sv
`timescale 1ns/1ps

module reg_bank
  (input  logic                                        aclk
   , input  logic                                      rst_n_i

   , reg_cmd_if.bank                                   cmd
   , input  logic                                      b_busy_i
   , input  logic                                      r_busy_i

   , output logic [hb_bridge_pkg::axil_data_width_lp-1:0] host_req_o
   , output logic                                      host_req_v_o
   , input  logic                                      host_req_yumi_i

   , input  logic [hb_bridge_pkg::axil_data_width_lp-1:0] mc_req_i
   , input  logic                                      mc_req_v_i
   , output logic                                      mc_req_ready_o

   , output logic [hb_bridge_pkg::dram_addr_width_lp-1:0] dram_base_o
   , output logic                                      sys_reset_o
   );

  import hb_bridge_pkg::*;

  logic [axil_data_width_lp-1:0]  sys_reset_r;
  logic [axil_data_width_lp-1:0]  dram_base_r;
  logic [axil_data_width_lp-1:0]  wmask;
  logic [reset_depth_lp-1:0]      reset_chain_r;
  logic                           exec;
  logic                           h2f_push;
  logic                           h2f_ready;
  logic [fifo_count_width_lp-1:0] h2f_count;
  logic [fifo_count_width_lp-1:0] h2f_free;
  logic [axil_data_width_lp-1:0]  f2h_data;
  logic                           f2h_v;
  logic                           f2h_yumi;
  logic [fifo_count_width_lp-1:0] f2h_count;
  logic [axil_data_width_lp-1:0]  rdata_n;
  logic [1:0]                     code_n;
  logic                           rsp_v_r;
  logic                           rsp_write_r;
  logic [axil_data_width_lp-1:0]  rsp_rdata_r;
  logic [1:0]                     rsp_code_r;

  // hold off while the response stage still owns a result of this kind
  assign cmd.cmd_ready = cmd.cmd_write ? ~b_busy_i : ~r_busy_i;
  assign exec          = cmd.cmd_v & cmd.cmd_ready;

  assign h2f_push = exec & cmd.cmd_write & (cmd.cmd_idx == reg_h2f_data_lp);
  assign f2h_yumi = exec & ~cmd.cmd_write & (cmd.cmd_idx == reg_f2h_data_lp) & f2h_v;
  assign h2f_free = fifo_count_width_lp'(fifo_depth_lp) - h2f_count;

  word_fifo h2f_fifo
    (.aclk     (aclk)
     ,.rst_n_i (rst_n_i)
     ,.data_i  (cmd.cmd_wdata)
     ,.v_i     (h2f_push)
     ,.ready_o (h2f_ready)
     ,.data_o  (host_req_o)
     ,.v_o     (host_req_v_o)
     ,.yumi_i  (host_req_yumi_i)
     ,.count_o (h2f_count)
     );

  word_fifo f2h_fifo
    (.aclk     (aclk)
     ,.rst_n_i (rst_n_i)
     ,.data_i  (mc_req_i)
     ,.v_i     (mc_req_v_i)
     ,.ready_o (mc_req_ready_o)
     ,.data_o  (f2h_data)
     ,.v_o     (f2h_v)
     ,.yumi_i  (f2h_yumi)
     ,.count_o (f2h_count)
     );

  ////////////////////
  // control registers
  ////////////////////
  always_comb
  begin
    for (int b = 0; b < axil_data_width_lp/8; b++)
      wmask[8*b +: 8] = {8{cmd.cmd_wstrb[b]}};
  end

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_reset_r <= '0;
      dram_base_r <= '0;
    end
    else if (exec & cmd.cmd_write)
    begin
      if (cmd.cmd_idx == reg_sys_reset_lp)
        sys_reset_r <= (sys_reset_r & ~wmask) | (cmd.cmd_wdata & wmask);
      if (cmd.cmd_idx == reg_dram_base_lp)
        dram_base_r <= (dram_base_r & ~wmask) | (cmd.cmd_wdata & wmask);
    end
  end

  assign dram_base_o = dram_base_r;

  // stored bit is active low, so the chain idles high
  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      reset_chain_r <= '1;
    else
      reset_chain_r <= {reset_chain_r[reset_depth_lp-2:0], ~sys_reset_r[0]};
  end

  assign sys_reset_o = reset_chain_r[reset_depth_lp-1];

  ////////////////////
  // result
  ////////////////////
  always_comb
  begin
    rdata_n = '0;
    code_n  = resp_okay_lp;
    if (cmd.cmd_write)
    begin
      // push into a full queue is dropped
      if ((cmd.cmd_idx == reg_h2f_data_lp) && !h2f_ready)
        code_n = resp_slverr_lp;
    end
    else
    begin
      case (cmd.cmd_idx)
        reg_sys_reset_lp: rdata_n = sys_reset_r;
        reg_dram_base_lp: rdata_n = dram_base_r;
        reg_h2f_free_lp:  rdata_n = axil_data_width_lp'(h2f_free);
        reg_f2h_count_lp: rdata_n = axil_data_width_lp'(f2h_count);
        reg_f2h_data_lp:
        begin
          if (f2h_v)
            rdata_n = f2h_data;
          else
            code_n = resp_slverr_lp;
        end
        default: rdata_n = '0;
      endcase
    end
  end

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_v_r <= 1'b0;
    else
      rsp_v_r <= exec;
  end

  always_ff @(posedge aclk)
  begin
    if (exec)
    begin
      rsp_write_r <= cmd.cmd_write;
      rsp_rdata_r <= rdata_n;
      rsp_code_r  <= code_n;
    end
  end

  assign cmd.rsp_v     = rsp_v_r;
  assign cmd.rsp_write = rsp_write_r;
  assign cmd.rsp_rdata = rsp_rdata_r;
  assign cmd.rsp_code  = rsp_code_r;

endmodule

//--- logic/axil_response.sv
`timescale 1ns/1ps

module axil_response
  (input  logic                                        aclk
   , input  logic                                      rst_n_i

   , reg_cmd_if.resp                                   rsp

   , output logic [1:0]                                s_axi_bresp_o
   , output logic                                      s_axi_bvalid_o
   , input  logic                                      s_axi_bready_i

   , output logic [hb_bridge_pkg::axil_data_width_lp-1:0] s_axi_rdata_o
   , output logic [1:0]                                s_axi_rresp_o
   , output logic                                      s_axi_rvalid_o
   , input  logic                                      s_axi_rready_i

   , output logic                                      b_busy_o
   , output logic                                      r_busy_o
   );

  logic b_load;
  logic r_load;
  logic bvalid_r;
  logic rvalid_r;

  assign b_load = rsp.rsp_v & rsp.rsp_write;
  assign r_load = rsp.rsp_v & ~rsp.rsp_write;

  // a strobe already on its way counts as busy too
  assign b_busy_o = bvalid_r | b_load;
  assign r_busy_o = rvalid_r | r_load;

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bvalid_r <= 1'b0;
      rvalid_r <= 1'b0;
    end
    else
    begin
      if (b_load)
        bvalid_r <= 1'b1;
      else if (s_axi_bready_i)
        bvalid_r <= 1'b0;
      if (r_load)
        rvalid_r <= 1'b1;
      else if (s_axi_rready_i)
        rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (b_load)
      s_axi_bresp_o <= rsp.rsp_code;
    if (r_load)
    begin
      s_axi_rdata_o <= rsp.rsp_rdata;
      s_axi_rresp_o <= rsp.rsp_code;
    end
  end

  assign s_axi_bvalid_o = bvalid_r;
  assign s_axi_rvalid_o = rvalid_r;

endmodule

//--- logic/dram_addr_remap.sv
`timescale 1ns/1ps

module dram_addr_remap
  (input  logic                                        aclk
   , input  logic                                      rst_n_i

   , input  logic [hb_bridge_pkg::dma_addr_width_lp-1:0]  dma_addr_i
   , input  logic [hb_bridge_pkg::cache_id_width_lp-1:0]  dma_cache_id_i
   , input  logic                                      dma_v_i

   , input  logic [hb_bridge_pkg::dram_addr_width_lp-1:0] dram_base_i

   , output logic [hb_bridge_pkg::dram_addr_width_lp-1:0] dram_addr_o
   , output logic                                      dram_v_o
   );

  import hb_bridge_pkg::*;

  dram_addr_u hash_n;
  dram_addr_u hash_r;
  logic       hash_v_r;

  // fold the cache id in above the line offset
  always_comb
  begin
    hash_n                    = '0;
    hash_n.fields.cache_id    = dma_cache_id_i;
    hash_n.fields.line_offset = dma_addr_i[line_offset_width_lp-1:0];
  end

  always_ff @(posedge aclk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      hash_v_r <= 1'b0;
      dram_v_o <= 1'b0;
    end
    else
    begin
      hash_v_r <= dma_v_i;
      dram_v_o <= hash_v_r;
    end
  end

  always_ff @(posedge aclk)
  begin
    hash_r      <= hash_n;
    dram_addr_o <= hash_r.flat + dram_base_i;
  end

endmodule

//--- logic/hb_bridge_top.sv
`timescale 1ns/1ps

module hb_bridge_top
  (input  logic                                          aclk
   , input  logic                                        rst_n_i

   , input  logic [hb_bridge_pkg::axil_addr_width_lp-1:0]   s_axi_awaddr_i
   , input  logic                                        s_axi_awvalid_i
   , output logic                                        s_axi_awready_o
   , input  logic [hb_bridge_pkg::axil_data_width_lp-1:0]   s_axi_wdata_i
   , input  logic [hb_bridge_pkg::axil_data_width_lp/8-1:0] s_axi_wstrb_i
   , input  logic                                        s_axi_wvalid_i
   , output logic                                        s_axi_wready_o
   , output logic [1:0]                                  s_axi_bresp_o
   , output logic                                        s_axi_bvalid_o
   , input  logic                                        s_axi_bready_i
   , input  logic [hb_bridge_pkg::axil_addr_width_lp-1:0]   s_axi_araddr_i
   , input  logic                                        s_axi_arvalid_i
   , output logic                                        s_axi_arready_o
   , output logic [hb_bridge_pkg::axil_data_width_lp-1:0]   s_axi_rdata_o
   , output logic [1:0]                                  s_axi_rresp_o
   , output logic                                        s_axi_rvalid_o
   , input  logic                                        s_axi_rready_i

   , output logic [hb_bridge_pkg::axil_data_width_lp-1:0]   host_req_o
   , output logic                                        host_req_v_o
   , input  logic                                        host_req_yumi_i

   , input  logic [hb_bridge_pkg::axil_data_width_lp-1:0]   mc_req_i
   , input  logic                                        mc_req_v_i
   , output logic                                        mc_req_ready_o

   , input  logic [hb_bridge_pkg::dma_addr_width_lp-1:0]    dma_addr_i
   , input  logic [hb_bridge_pkg::cache_id_width_lp-1:0]    dma_cache_id_i
   , input  logic                                        dma_v_i
   , output logic [hb_bridge_pkg::dram_addr_width_lp-1:0]   dram_addr_o
   , output logic                                        dram_v_o

   , output logic                                        sys_reset_o
   );

  import hb_bridge_pkg::*;

  logic                          b_busy;
  logic                          r_busy;
  logic [dram_addr_width_lp-1:0] dram_base;

  reg_cmd_if cmd_if (.aclk(aclk));

  ////////////////////
  // register pipeline
  ////////////////////
  axil_front front
    (.aclk             (aclk)
     ,.rst_n_i         (rst_n_i)
     ,.s_axi_awaddr_i  (s_axi_awaddr_i)
     ,.s_axi_awvalid_i (s_axi_awvalid_i)
     ,.s_axi_awready_o (s_axi_awready_o)
     ,.s_axi_wdata_i   (s_axi_wdata_i)
     ,.s_axi_wstrb_i   (s_axi_wstrb_i)
     ,.s_axi_wvalid_i  (s_axi_wvalid_i)
     ,.s_axi_wready_o  (s_axi_wready_o)
     ,.s_axi_araddr_i  (s_axi_araddr_i)
     ,.s_axi_arvalid_i (s_axi_arvalid_i)
     ,.s_axi_arready_o (s_axi_arready_o)
     ,.cmd             (cmd_if.front)
     );

  reg_bank bank
    (.aclk             (aclk)
     ,.rst_n_i         (rst_n_i)
     ,.cmd             (cmd_if.bank)
     ,.b_busy_i        (b_busy)
     ,.r_busy_i        (r_busy)
     ,.host_req_o      (host_req_o)
     ,.host_req_v_o    (host_req_v_o)
     ,.host_req_yumi_i (host_req_yumi_i)
     ,.mc_req_i        (mc_req_i)
     ,.mc_req_v_i      (mc_req_v_i)
     ,.mc_req_ready_o  (mc_req_ready_o)
     ,.dram_base_o     (dram_base)
     ,.sys_reset_o     (sys_reset_o)
     );

  axil_response response
    (.aclk            (aclk)
     ,.rst_n_i        (rst_n_i)
     ,.rsp            (cmd_if.resp)
     ,.s_axi_bresp_o  (s_axi_bresp_o)
     ,.s_axi_bvalid_o (s_axi_bvalid_o)
     ,.s_axi_bready_i (s_axi_bready_i)
     ,.s_axi_rdata_o  (s_axi_rdata_o)
     ,.s_axi_rresp_o  (s_axi_rresp_o)
     ,.s_axi_rvalid_o (s_axi_rvalid_o)
     ,.s_axi_rready_i (s_axi_rready_i)
     ,.b_busy_o       (b_busy)
     ,.r_busy_o       (r_busy)
     );

  // dma side path, shares only the base register
  dram_addr_remap remap
    (.aclk            (aclk)
     ,.rst_n_i        (rst_n_i)
     ,.dma_addr_i     (dma_addr_i)
     ,.dma_cache_id_i (dma_cache_id_i)
     ,.dma_v_i        (dma_v_i)
     ,.dram_base_i    (dram_base)
     ,.dram_addr_o    (dram_addr_o)
     ,.dram_v_o       (dram_v_o)
     );

endmodule

//--- sim/hb_bridge_tb_table.svh
`ifndef HB_BRIDGE_TB_TABLE_SVH
`define HB_BRIDGE_TB_TABLE_SVH

typedef enum {op_wr, op_rd, op_mc, op_pop, op_dma, op_sys} op_e;

// for op_sys, addr is the cycle bound and exp_data the expected level
// for op_dma, addr is the cache-side address and data the cache id
typedef struct {
  op_e         op;
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
  logic [31:0] exp_data;
  logic [1:0]  exp_resp;
  string       name;
} row_s;

row_s        rows[$];
logic [31:0] lfsr_state = 32'h7729_a580;

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic add_row(op_e op, logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                       logic [31:0] exp_data, logic [1:0] exp_resp, string name);
  row_s r;
  r = '{op, addr, data, strb, exp_data, exp_resp, name};
  rows.push_back(r);
endtask

task automatic build_table();
  logic [31:0] base;
  logic [31:0] lane;
  logic [31:0] word [5];
  logic [31:0] addr;
  logic [3:0]  id;
  add_row(op_sys, 0, 0, 4'h0, 1, resp_okay_lp, "sys_reset_o high after reset");
  add_row(op_rd, 'h000, 0, 4'h0, 0, resp_okay_lp, "reset register reads zero");
  add_row(op_rd, 'h3fc, 0, 4'h0, 0, resp_okay_lp, "unmapped index reads zero");
  add_row(op_wr, 'h000, 1, 4'hf, 0, resp_okay_lp, "release fabric reset");
  add_row(op_sys, reset_depth_lp + 3, 0, 4'h0, 0, resp_okay_lp, "sys_reset_o falls");
  add_row(op_rd, 'h000, 0, 4'h0, 1, resp_okay_lp, "reset register reads one");
  // dram base, full word and then byte lane 0 alone
  base = take_bits(32);
  lane = take_bits(32);
  add_row(op_wr, 'h004, base, 4'hf, 0, resp_okay_lp, "write dram base");
  add_row(op_rd, 'h004, 0, 4'h0, base, resp_okay_lp, "dram base reads back");
  base = {base[31:8], lane[7:0]};
  add_row(op_wr, 'h004, lane, 4'h1, 0, resp_okay_lp, "write dram base lane 0");
  add_row(op_rd, 'h004, 0, 4'h0, base, resp_okay_lp, "only lane 0 changed");
  // host queue, four fit and the fifth bounces
  for (int i = 0; i < 5; i++)
    word[i] = take_bits(32);
  add_row(op_rd, 'h00c, 0, 4'h0, fifo_depth_lp, resp_okay_lp, "host queue all free");
  for (int i = 0; i < 4; i++)
    add_row(op_wr, 'h008, word[i], 4'hf, 0, resp_okay_lp, $sformatf("host push %0d", i));
  add_row(op_rd, 'h00c, 0, 4'h0, 0, resp_okay_lp, "host queue no free slot");
  add_row(op_wr, 'h008, word[4], 4'hf, 0, resp_slverr_lp, "push to full host queue");
  for (int i = 0; i < 4; i++)
    add_row(op_pop, 0, 0, 4'h0, word[i], resp_okay_lp, $sformatf("host pop %0d", i));
  add_row(op_rd, 'h00c, 0, 4'h0, fifo_depth_lp, resp_okay_lp, "host queue free again");
  // fabric queue
  add_row(op_rd, 'h014, 0, 4'h0, 0, resp_okay_lp, "fabric queue empty");
  for (int i = 0; i < 3; i++)
  begin
    word[i] = take_bits(32);
    add_row(op_mc, 0, word[i], 4'h0, 0, resp_okay_lp, $sformatf("fabric push %0d", i));
  end
  add_row(op_rd, 'h014, 0, 4'h0, 3, resp_okay_lp, "fabric count three");
  for (int i = 0; i < 3; i++)
    add_row(op_rd, 'h010, 0, 4'h0, word[i], resp_okay_lp, $sformatf("fabric pop %0d", i));
  add_row(op_rd, 'h014, 0, 4'h0, 0, resp_okay_lp, "fabric count zero");
  add_row(op_rd, 'h010, 0, 4'h0, 0, resp_slverr_lp, "pop from empty fabric queue");
  // remap, a back-to-back burst and a short one after a gap
  for (int i = 0; i < 8; i++)
  begin
    addr = take_bits(28);
    id   = 4'(take_bits(4));
    if (i == 6)
      add_row(op_sys, 0, 0, 4'h0, 0, resp_okay_lp, "sys_reset_o stays low");
    add_row(op_dma, addr, id, 4'h0, base + {4'h0, id, addr[23:0]}, resp_okay_lp,
            $sformatf("remap %0d", i));
  end
endtask

`endif

//--- sim/hb_bridge_tb.sv
`timescale 1ns/1ps

module hb_bridge_tb;

  import hb_bridge_pkg::*;

  localparam int handshake_limit_lp = 20;

  logic                            aclk;
  logic                            rst_n;
  logic [axil_addr_width_lp-1:0]   awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [axil_data_width_lp-1:0]   wdata;
  logic [axil_data_width_lp/8-1:0] wstrb;
  logic                            wvalid;
  logic                            wready;
  logic [1:0]                      bresp;
  logic                            bvalid;
  logic                            bready;
  logic [axil_addr_width_lp-1:0]   araddr;
  logic                            arvalid;
  logic                            arready;
  logic [axil_data_width_lp-1:0]   rdata;
  logic [1:0]                      rresp;
  logic                            rvalid;
  logic                            rready;
  logic [axil_data_width_lp-1:0]   host_req;
  logic                            host_req_v;
  logic                            host_req_yumi;
  logic [axil_data_width_lp-1:0]   mc_req;
  logic                            mc_req_v;
  logic                            mc_req_ready;
  logic [dma_addr_width_lp-1:0]    dma_addr;
  logic [cache_id_width_lp-1:0]    dma_cache_id;
  logic                            dma_v;
  logic [dram_addr_width_lp-1:0]   dram_addr;
  logic                            dram_v;
  logic                            sys_reset;

  int         errors;
  int         failed;
  int         dma_row;
  bit         row_bad[];
  logic [1:0] hist_v = '0;
  int         hist_row [2];
  logic       live = 1'b0;

  `include "hb_bridge_tb_table.svh"

  hb_bridge_top DUT
    (.aclk(aclk), .rst_n_i(rst_n)
     ,.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready)
     ,.s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid)
     ,.s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid)
     ,.s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid)
     ,.s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp)
     ,.s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready)
     ,.host_req_o(host_req), .host_req_v_o(host_req_v), .host_req_yumi_i(host_req_yumi)
     ,.mc_req_i(mc_req), .mc_req_v_i(mc_req_v), .mc_req_ready_o(mc_req_ready)
     ,.dma_addr_i(dma_addr), .dma_cache_id_i(dma_cache_id), .dma_v_i(dma_v)
     ,.dram_addr_o(dram_addr), .dram_v_o(dram_v), .sys_reset_o(sys_reset)
     );

  always #50 aclk = ~aclk;

  ////////////////////
  // reporting
  ////////////////////
  task automatic report_failure(int row, string what);
    $display("ERROR %s: %s", rows[row].name, what);
    errors++;
    row_bad[row] = 1'b1;
  endtask

  task automatic check_value(int row, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH %s: expected %h, actual %h", rows[row].name, expected, actual);
      errors++;
      row_bad[row] = 1'b1;
    end
  endtask

  task automatic finish_row(int row);
    $display("%s %s", row_bad[row] ? "FAIL" : "ok  ", rows[row].name);
  endtask

  ////////////////////
  // bus drivers
  ////////////////////
  task automatic axil_write(int row);
    int n;
    @(negedge aclk);
    awaddr  = rows[row].addr[axil_addr_width_lp-1:0];
    wdata   = rows[row].data;
    wstrb   = rows[row].strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // awready and wready follow the valids within the same cycle
    #1;
    n = 0;
    while (!(awready && wready) && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      #1;
      n++;
    end
    assert (awready && wready)
    else
      report_failure(row, "write address and data were never accepted");
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    assert (bvalid)
    else
      report_failure(row, "no write response arrived");
    if (bvalid)
      check_value(row, rows[row].exp_resp, bresp);
  endtask

  task automatic axil_read(int row);
    int n;
    @(negedge aclk);
    araddr  = rows[row].addr[axil_addr_width_lp-1:0];
    arvalid = 1'b1;
    #1;
    n = 0;
    while (!arready && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      #1;
      n++;
    end
    assert (arready)
    else
      report_failure(row, "read address was never accepted");
    @(negedge aclk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    assert (rvalid)
    else
      report_failure(row, "no read response arrived");
    if (rvalid)
    begin
      check_value(row, rows[row].exp_data, rdata);
      check_value(row, rows[row].exp_resp, rresp);
    end
  endtask

  task automatic fabric_push(int row);
    int n;
    @(negedge aclk);
    n = 0;
    while (!mc_req_ready && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    assert (mc_req_ready)
    else
      report_failure(row, "fabric queue never became ready");
    mc_req   = rows[row].data;
    mc_req_v = mc_req_ready;
    @(negedge aclk);
    mc_req_v = 1'b0;
  endtask

  task automatic host_pop(int row);
    int n;
    @(negedge aclk);
    n = 0;
    while (!host_req_v && n < handshake_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    assert (host_req_v)
    else
      report_failure(row, "host queue had no word to pop");
    if (host_req_v)
    begin
      check_value(row, rows[row].exp_data, host_req);
      host_req_yumi = 1'b1;
      @(negedge aclk);
      host_req_yumi = 1'b0;
    end
  endtask

  // waits at most addr cycles for the expected level
  task automatic sys_reset_wait(int row);
    int n;
    @(negedge aclk);
    n = 0;
    while (sys_reset !== rows[row].exp_data[0] && n < rows[row].addr)
    begin
      @(negedge aclk);
      n++;
    end
    check_value(row, rows[row].exp_data, {31'b0, sys_reset});
  endtask

  task automatic dma_send(int row);
    @(negedge aclk);
    dma_addr     = rows[row].addr[dma_addr_width_lp-1:0];
    dma_cache_id = rows[row].data[cache_id_width_lp-1:0];
    dma_row      = row;
    dma_v        = 1'b1;
  endtask

  ////////////////////
  // remap monitor
  ////////////////////
  always @(posedge aclk)
  begin
    live        <= rst_n;
    hist_v      <= {hist_v[0], dma_v};
    hist_row[0] <= dma_row;
    hist_row[1] <= hist_row[0];
  end

  always @(negedge aclk)
  begin
    if (live && hist_v[1])
    begin
      assert (dram_v)
      else
        report_failure(hist_row[1], "dram_v_o was low two cycles after dma_v_i");
      check_value(hist_row[1], rows[hist_row[1]].exp_data, dram_addr);
      finish_row(hist_row[1]);
    end
    else if (live)
    begin
      assert (!dram_v)
      else
      begin
        $display("ERROR dram_v_o high with no request two cycles earlier");
        errors++;
      end
    end
  end

  // limit scales with the table length
  initial
  begin
    #1;
    #(rows.size() * 40 * 100);
    $display("watchdog expired after %0d table rows worth of time", rows.size());
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    aclk          = 1'b0;
    rst_n         = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b1;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b1;
    host_req_yumi = 1'b0;
    mc_req        = '0;
    mc_req_v      = 1'b0;
    dma_addr      = '0;
    dma_cache_id  = '0;
    dma_v         = 1'b0;
    dma_row       = 0;
    errors        = 0;
    failed        = 0;
    build_table();
    row_bad = new[rows.size()];
    repeat (5) @(negedge aclk);
    rst_n = 1'b1;

    foreach (rows[r])
    begin
      if (rows[r].op != op_dma && dma_v)
      begin
        @(negedge aclk);
        dma_v = 1'b0;
      end
      case (rows[r].op)
        op_wr:   axil_write(r);
        op_rd:   axil_read(r);
        op_mc:   fabric_push(r);
        op_pop:  host_pop(r);
        op_sys:  sys_reset_wait(r);
        op_dma:  dma_send(r);
        default: report_failure(r, "row holds an unknown operation");
      endcase
      if (rows[r].op != op_dma)
        finish_row(r);
    end

    // let the last remap results drain out
    @(negedge aclk);
    dma_v = 1'b0;
    repeat (3) @(negedge aclk);

    foreach (row_bad[r])
      failed += row_bad[r];
    $display("%0d tests, %0d failed, %0d errors", rows.size(), failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- hb_bridge.f
+incdir+sim
logic/hb_bridge_pkg.sv
logic/reg_cmd_if.sv
logic/word_fifo.sv
logic/axil_front.sv
logic/reg_bank.sv
logic/axil_response.sv
logic/dram_addr_remap.sv
logic/hb_bridge_top.sv
sim/hb_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the bridge and its testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hb_bridge_tb \
  -f hb_bridge.f -o hb_bridge_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/hb_bridge_sim > sim.log 2>&1
cat sim.log

grep -q "^Done: no errors$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
